/* include/frv_ex_config.svh */
// Build-time sizes of the execute stage
// Data word, register index, micro-op, unit vector, multiplier steps

`ifndef FRV_EX_CONFIG_SVH
`define FRV_EX_CONFIG_SVH

// ------------------------------------------------
// Datapath widths
// ------------------------------------------------
`define FRV_XLEN      32   // One data word
`define FRV_REG_W     5    // GPR index
`define FRV_UOP_W     5    // Micro-op code
`define FRV_FU_W      5    // One-hot unit vector

// ------------------------------------------------
// Multiplier
// ------------------------------------------------
`define FRV_MUL_STEPS 32   // Shift-add iterations per product

`endif

/* run_sim.sh */
#!/bin/bash
# Build and run the execute-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_execute \
    -o tb_execute > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_execute > sim.log 2>&1
cat sim.log

grep -q "All tests passed" sim.log && echo "Simulation PASSED" && exit 0 || \
    { echo "Simulation FAILED"; exit 1; }

/* sim/tb_execute.sv */
// Table-driven testbench of the execute stage
// Clock, reset, stage-3 sink with back-pressure, flush, checks and timeouts

`include "frv_ex_config.svh"

module tb_execute;

    localparam int PERIOD  = 4;
    localparam int SEED    = 95221;
    localparam int TIMEOUT = 200;     // Cycles per wait

    typedef struct {
        frv_ex_pkg::fu_t       fu;
        frv_ex_pkg::uop_t      uop;
        frv_ex_pkg::word_t     a, b, c;
        frv_ex_pkg::reg_addr_t rd;
        frv_ex_pkg::word_t     exp_a;
        frv_ex_pkg::word_t     exp_b;
        frv_ex_pkg::uop_t      exp_uop;
        logic                  chk_b;      // opr_b only loads for store and CSR
    } entry_t;

    logic g_clk, g_resetn;
    frv_ex_pkg::reg_addr_t i_s2_rd;
    frv_ex_pkg::word_t     i_s2_opr_a, i_s2_opr_b, i_s2_opr_c;
    frv_ex_pkg::uop_t      i_s2_uop;
    frv_ex_pkg::fu_t       i_s2_fu;
    logic i_s2_trap, i_s2_valid, o_s2_busy, i_flush, i_s3_busy;
    logic [1:0]            i_s2_size;
    logic [31:0]           i_s2_instr;
    frv_ex_pkg::reg_addr_t o_fwd_s2_rd, o_s3_rd;
    frv_ex_pkg::word_t     o_fwd_s2_wdata, o_s3_opr_a, o_s3_opr_b;
    logic o_fwd_s2_load, o_fwd_s2_csr, o_s3_trap, o_s3_valid;
    frv_ex_pkg::uop_t      o_s3_uop;
    frv_ex_pkg::fu_t       o_s3_fu;
    logic [1:0]            o_s3_size;
    logic [31:0]           o_s3_instr;

    entry_t table_q[$];
    int     sink_count;

    frv_pipeline_execute u_dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #(PERIOD / 2) g_clk = ~g_clk;
    end

    // Stage-3 sink, counts every handshake
    always @(posedge g_clk) begin
        if (g_resetn && o_s3_valid && !i_s3_busy) sink_count <= sink_count + 1;
    end

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else
            report_fail($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    function automatic frv_ex_pkg::fu_t fu_onehot(input int pos);
        return frv_ex_pkg::fu_t'(1 << pos);
    endfunction

    task automatic add_entry(input int fu_pos, input frv_ex_pkg::uop_t uop,
                             input logic [31:0] a, b, c, exp_a, exp_b,
                             input frv_ex_pkg::uop_t exp_uop, input logic chk_b);
        entry_t e;
        e.fu = fu_onehot(fu_pos);
        e.uop = uop;
        e.a = a;
        e.b = b;
        e.c = c;
        e.rd = frv_ex_pkg::reg_addr_t'(table_q.size() + 1);
        e.exp_a = exp_a;
        e.exp_b = exp_b;
        e.exp_uop = exp_uop;
        e.chk_b = chk_b;
        table_q.push_back(e);
    endtask

    // Offer one entry, optionally keep it in stage 3 with s3_busy
    task automatic offer_entry(input entry_t e, input int idx, input logic hold);
        int t;
        @(posedge g_clk);
        i_s2_fu    <= e.fu;
        i_s2_uop   <= e.uop;
        i_s2_opr_a <= e.a;
        i_s2_opr_b <= e.b;
        i_s2_opr_c <= e.c;
        i_s2_rd    <= e.rd;
        i_s2_trap  <= idx[0];
        i_s2_size  <= idx[1:0];
        i_s2_instr <= 32'h1000_0000 + idx;
        i_s2_valid <= 1'b1;
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge g_clk);
            check_word("o_fwd_s2_load", o_fwd_s2_load,
                       e.fu[frv_ex_pkg::FU_LSU] && e.uop == frv_ex_pkg::LSU_LOAD);
            check_word("o_fwd_s2_csr", o_fwd_s2_csr, e.fu[frv_ex_pkg::FU_CSR]);
            check_word("o_fwd_s2_rd", o_fwd_s2_rd, e.rd);
            if (!o_s2_busy) begin
                check_word("o_fwd_s2_wdata", o_fwd_s2_wdata, e.exp_a);
                break;
            end
        end
        if (t == TIMEOUT) report_fail("Timeout waiting for stage 2 acceptance");
        @(posedge g_clk);                           // Accepted at this edge
        i_s2_valid <= 1'b0;
        i_s3_busy  <= hold;
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge g_clk);
            if (o_s3_valid) break;
        end
        if (t == TIMEOUT) report_fail("Timeout waiting for stage 3 valid");
    endtask

    task automatic check_s3(input entry_t e, input int idx);
        check_word("o_s3_rd", o_s3_rd, e.rd);
        check_word("o_s3_opr_a", o_s3_opr_a, e.exp_a);
        if (e.chk_b) check_word("o_s3_opr_b", o_s3_opr_b, e.exp_b);
        check_word("o_s3_uop", o_s3_uop, e.exp_uop);
        check_word("o_s3_fu", o_s3_fu, e.fu);
        check_word("o_s3_trap", o_s3_trap, idx[0]);
        check_word("o_s3_size", o_s3_size, idx[1:0]);
        check_word("o_s3_instr", o_s3_instr, 32'h1000_0000 + idx);
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        int gaps;
        entry_t e;
        logic [31:0] snap_b;
        void'($urandom(SEED));
        g_resetn = 1'b0;
        i_s2_rd = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_s2_uop = frv_ex_pkg::ALU_ADD;
        i_s2_fu = '0;
        i_s2_trap = 1'b0;
        i_s2_size = '0;
        i_s2_instr = '0;
        i_s2_valid = 1'b0;
        i_flush = 1'b0;
        i_s3_busy = 1'b0;
        sink_count = 0;

        // ALU, edge operands
        add_entry(0, frv_ex_pkg::ALU_ADD, 32'h7fffffff, 32'h1, 0, 32'h80000000, 0,
                  frv_ex_pkg::ALU_ADD, 0);
        add_entry(0, frv_ex_pkg::ALU_SUB, 32'h0, 32'h1, 0, 32'hffffffff, 0,
                  frv_ex_pkg::ALU_SUB, 0);
        add_entry(0, frv_ex_pkg::ALU_XOR, 32'hf0f0f0f0, 32'hff00ff00, 0, 32'h0ff00ff0, 0,
                  frv_ex_pkg::ALU_XOR, 0);
        add_entry(0, frv_ex_pkg::ALU_OR, 32'hf0f0f0f0, 32'hff00ff00, 0, 32'hfff0fff0, 0,
                  frv_ex_pkg::ALU_OR, 0);
        add_entry(0, frv_ex_pkg::ALU_AND, 32'hf0f0f0f0, 32'hff00ff00, 0, 32'hf000f000, 0,
                  frv_ex_pkg::ALU_AND, 0);
        add_entry(0, frv_ex_pkg::ALU_SLL, 32'h1, 32'h24, 0, 32'h10, 0,
                  frv_ex_pkg::ALU_SLL, 0);                          // Only low 5 bits shift
        add_entry(0, frv_ex_pkg::ALU_SRL, 32'h80000000, 32'd31, 0, 32'h1, 0,
                  frv_ex_pkg::ALU_SRL, 0);
        add_entry(0, frv_ex_pkg::ALU_SRA, 32'h80000000, 32'd4, 0, 32'hf8000000, 0,
                  frv_ex_pkg::ALU_SRA, 0);
        add_entry(0, frv_ex_pkg::ALU_SLT, 32'hffffffff, 32'h1, 0, 32'h1, 0,
                  frv_ex_pkg::ALU_SLT, 0);
        add_entry(0, frv_ex_pkg::ALU_SLTU, 32'hffffffff, 32'h1, 0, 32'h0, 0,
                  frv_ex_pkg::ALU_SLTU, 0);
        // Branches, target is c with bit 0 cleared
        add_entry(3, frv_ex_pkg::CFU_BEQ, 5, 5, 32'h1235, 32'h1234, 0,
                  frv_ex_pkg::CFU_TAKEN, 0);
        add_entry(3, frv_ex_pkg::CFU_BNE, 5, 5, 32'h1235, 32'h1234, 0,
                  frv_ex_pkg::CFU_NOT_TAKEN, 0);
        add_entry(3, frv_ex_pkg::CFU_BLT, 32'hfffffff0, 1, 32'h1235, 32'h1234, 0,
                  frv_ex_pkg::CFU_TAKEN, 0);
        add_entry(3, frv_ex_pkg::CFU_BGE, 32'hfffffff0, 1, 32'h1235, 32'h1234, 0,
                  frv_ex_pkg::CFU_NOT_TAKEN, 0);
        add_entry(3, frv_ex_pkg::CFU_BLTU, 32'hfffffff0, 1, 32'h1235, 32'h1234, 0,
                  frv_ex_pkg::CFU_NOT_TAKEN, 0);
        add_entry(3, frv_ex_pkg::CFU_BGEU, 32'hfffffff0, 1, 32'h1235, 32'h1234, 0,
                  frv_ex_pkg::CFU_TAKEN, 0);
        add_entry(3, frv_ex_pkg::CFU_JALI, 32'h40, 32'h8, 32'h2001, 32'h2000, 0,
                  frv_ex_pkg::CFU_JALI, 0);
        add_entry(3, frv_ex_pkg::CFU_JALR, 32'h1000, 32'h7, 32'h2001, 32'h1006, 0,
                  frv_ex_pkg::CFU_JALR, 0);
        // Memory and CSR
        add_entry(2, frv_ex_pkg::LSU_LOAD, 32'h1000, 32'h24, 0, 32'h1024, 0,
                  frv_ex_pkg::LSU_LOAD, 0);
        add_entry(2, frv_ex_pkg::LSU_STORE, 32'h2000, 32'hfffffffc, 32'hdeadbeef,
                  32'h1ffc, 32'hdeadbeef, frv_ex_pkg::LSU_STORE, 1);
        add_entry(4, frv_ex_pkg::CSR_OP, 32'h12345678, 32'h0, 32'hcafef00d,
                  32'h12345678, 32'hcafef00d, frv_ex_pkg::CSR_OP, 1);
        // Multiplies, -2 times 3 and -2 times 0x80000000
        add_entry(1, frv_ex_pkg::MUL_MUL, 32'hfffffffe, 32'h3, 0, 32'hfffffffa, 0,
                  frv_ex_pkg::MUL_MUL, 0);
        add_entry(1, frv_ex_pkg::MUL_MULH, 32'hfffffffe, 32'h80000000, 0, 32'h1, 0,
                  frv_ex_pkg::MUL_MULH, 0);
        add_entry(1, frv_ex_pkg::MUL_MULHU, 32'hfffffffe, 32'h80000000, 0, 32'h7fffffff, 0,
                  frv_ex_pkg::MUL_MULHU, 0);
        add_entry(1, frv_ex_pkg::MUL_MULHSU, 32'hfffffffe, 32'h80000000, 0, 32'hffffffff, 0,
                  frv_ex_pkg::MUL_MULHSU, 0);

        repeat (10) @(posedge g_clk);
        g_resetn <= 1'b1;

        foreach (table_q[i]) begin
            gaps = $urandom % 4;                    // Zero means no back-pressure
            offer_entry(table_q[i], i, gaps != 0);
            check_s3(table_q[i], i);
            snap_b = o_s3_opr_b;
            repeat (gaps) begin
                @(negedge g_clk);
                assert (o_s3_valid && o_s2_busy) else
                    report_fail("Stage 3 item dropped or stage 2 not stalled");
                check_s3(table_q[i], i);
                check_word("o_s3_opr_b", o_s3_opr_b, snap_b);
            end
            if (gaps != 0) begin
                @(posedge g_clk);
                i_s3_busy <= 1'b0;
            end
        end

        // Flush an item held in stage 3, then run one more entry
        e = table_q[0];
        offer_entry(e, 0, 1'b1);
        @(posedge g_clk);
        i_flush <= 1'b1;
        @(posedge g_clk);
        i_flush <= 1'b0;
        @(negedge g_clk);
        assert (!o_s3_valid) else report_fail("Stage 3 still valid after flush");
        @(posedge g_clk);
        i_s3_busy <= 1'b0;
        e = table_q[table_q.size() - 1];
        offer_entry(e, 7, 1'b0);
        check_s3(e, 7);
        repeat (3) @(posedge g_clk);

        if (sink_count == table_q.size() + 1) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("[FAIL] sink_count got %h expected %h", sink_count, table_q.size() + 1);
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

/* sources.f */
+incdir+include
verilog/frv_ex_pkg.sv
verilog/frv_alu.sv
verilog/frv_imul.sv
verilog/frv_pipeline_register.sv
verilog/frv_pipeline_execute.sv
sim/tb_execute.sv

/* verilog/frv_alu.sv */
// Combinational integer ALU
// Shared add/subtract, barrel shifter, logic ops, comparator and flags

module frv_alu (
    input  frv_ex_pkg::word_t i_lhs,            // Left operand
    input  frv_ex_pkg::word_t i_rhs,            // Right operand
    input  logic              i_op_add,
    input  logic              i_op_sub,
    input  logic              i_op_xor,
    input  logic              i_op_or,
    input  logic              i_op_and,
    input  logic              i_op_shf,         // Any shift
    input  logic              i_op_shf_left,    // Shift direction
    input  logic              i_op_shf_arith,   // Sign fill on right shift
    input  logic              i_op_cmp,         // Compare, slt or branch
    input  logic              i_op_unsigned,    // Unsigned compare
    output frv_ex_pkg::word_t o_result,
    output frv_ex_pkg::word_t o_add_result,     // Raw adder output
    output logic              o_lt,
    output logic              o_eq
);

    localparam int XL  = $bits(frv_ex_pkg::word_t);
    localparam int SHW = $clog2(XL);

    logic              sub_mode;
    frv_ex_pkg::word_t rhs_addend;
    logic [XL:0]       adder_out;
    logic              lt_signed;
    logic              lt_unsigned;
    logic [SHW-1:0]    shamt;
    frv_ex_pkg::word_t shf_right;
    frv_ex_pkg::word_t shf_result;

    // ------------------------------------------------
    // Adder, subtracts for sub and all compares
    // ------------------------------------------------
    assign sub_mode   = i_op_sub || i_op_cmp;
    assign rhs_addend = sub_mode ? ~i_rhs : i_rhs;                // Two's complement invert
    assign adder_out  = {1'b0, i_lhs} + {1'b0, rhs_addend} + {{XL{1'b0}}, sub_mode};

    assign o_add_result = adder_out[XL-1:0];

    // No borrow out means lhs >= rhs unsigned
    assign lt_unsigned = !adder_out[XL];
    assign lt_signed   = (i_lhs[XL-1] != i_rhs[XL-1]) ? i_lhs[XL-1] :   // Signs differ
                                                        adder_out[XL-1];

    assign o_lt = i_op_unsigned ? lt_unsigned : lt_signed;
    assign o_eq = i_lhs == i_rhs;

    // ------------------------------------------------
    // Shifter
    // ------------------------------------------------
    assign shamt      = i_rhs[SHW-1:0];                           // Low bits only
    assign shf_right  = i_op_shf_arith ? frv_ex_pkg::word_t'($signed(i_lhs) >>> shamt) :
                                         i_lhs >> shamt;
    assign shf_result = i_op_shf_left ? i_lhs << shamt : shf_right;

    // ------------------------------------------------
    // Result select, strobes are one-hot
    // ------------------------------------------------
    assign o_result = {XL{i_op_add || i_op_sub}} & o_add_result        |
                      {XL{i_op_xor}}             & (i_lhs ^ i_rhs)     |
                      {XL{i_op_or}}              & (i_lhs | i_rhs)     |
                      {XL{i_op_and}}             & (i_lhs & i_rhs)     |
                      {XL{i_op_shf}}             & shf_result          |
                      {XL{i_op_cmp}}             & {{(XL-1){1'b0}}, o_lt};

    // Decode upstream must never select two results at once
    always_comb begin
        a_one_result_op : assert ($onehot0({i_op_add, i_op_sub, i_op_xor, i_op_or,
                                            i_op_and, i_op_shf, i_op_cmp}));
    end

endmodule

/* verilog/frv_ex_pkg.sv */
// Shared types of the execute stage
// Word, register index, unit vector, micro-op codes, stage-3 control

`include "frv_ex_config.svh"

package frv_ex_pkg;

    typedef logic [`FRV_XLEN-1:0]  word_t;      // One data word
    typedef logic [`FRV_REG_W-1:0] reg_addr_t;  // Register index
    typedef logic [`FRV_FU_W-1:0]  fu_t;        // One-hot unit select

    // Bit positions in fu_t
    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_LSU = 2;
    localparam int FU_CFU = 3;
    localparam int FU_CSR = 4;

    typedef enum logic [`FRV_UOP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,        // Arithmetic and logic
        ALU_SLL, ALU_SRL, ALU_SRA,                          // Shifts
        ALU_SLT, ALU_SLTU,                                  // Set less than
        MUL_MUL, MUL_MULH, MUL_MULHU, MUL_MULHSU,           // Multiplier
        LSU_LOAD, LSU_STORE,                                // Memory access
        CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE,                 // Signed and equality branches
        CFU_BLTU, CFU_BGEU,                                 // Unsigned branches
        CFU_JALI, CFU_JALR,                                 // Jumps
        CFU_TAKEN, CFU_NOT_TAKEN,                           // Resolved branch outcome
        CSR_OP                                              // CSR access
    } uop_t;

    // Control half of the stage-3 register
    typedef struct packed {
        reg_addr_t   rd;     // Destination register
        uop_t        uop;    // Micro-op, branches resolved
        fu_t         fu;     // Unit
        logic        trap;   // Trap raised earlier
        logic [1:0]  size;   // Instruction size
        logic [31:0] instr;  // Instruction word
    } s3_ctrl_t;

endpackage

/* verilog/frv_imul.sv */
// Iterative shift-add multiplier
// Magnitude datapath, one partial product per cycle, sign fix on output

`include "frv_ex_config.svh"

module frv_imul (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     i_valid,        // Multiply offered, held until done
    input  logic                     i_restart,      // Progress or flush
    input  logic                     i_lhs_signed,
    input  logic                     i_rhs_signed,
    input  frv_ex_pkg::word_t        i_rs1,
    input  frv_ex_pkg::word_t        i_rs2,
    output logic                     o_ready,        // Product complete
    output logic [2*`FRV_XLEN-1:0]   o_result
);

    localparam int XL = `FRV_XLEN;
    localparam int CW = $clog2(`FRV_MUL_STEPS + 1);

    logic [CW-1:0]     step_cnt;
    logic [2*XL-1:0]   acc;                          // {partial sum, remaining multiplier}
    logic              lhs_neg;
    logic              rhs_neg;
    frv_ex_pkg::word_t lhs_mag;
    frv_ex_pkg::word_t rhs_mag;
    frv_ex_pkg::word_t lo_in;
    frv_ex_pkg::word_t hi_in;
    logic [XL:0]       partial;
    logic              step;

    // ------------------------------------------------
    // Operand magnitudes, inputs stable while busy
    // ------------------------------------------------
    assign lhs_neg = i_lhs_signed && i_rs1[XL-1];
    assign rhs_neg = i_rhs_signed && i_rs2[XL-1];
    assign lhs_mag = lhs_neg ? -i_rs1 : i_rs1;
    assign rhs_mag = rhs_neg ? -i_rs2 : i_rs2;

    assign o_ready = step_cnt == CW'(`FRV_MUL_STEPS);
    assign step    = i_valid && !o_ready;

    // First step seeds the multiplier into the low half
    assign lo_in   = (step_cnt == '0) ? rhs_mag : acc[XL-1:0];
    assign hi_in   = (step_cnt == '0) ? '0      : acc[2*XL-1:XL];
    assign partial = {1'b0, hi_in} + (lo_in[0] ? {1'b0, lhs_mag} : '0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            step_cnt <= '0;
        end else if (i_restart) begin
            step_cnt <= '0;                          // Abandon or retire
        end else if (step) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (step) begin
            acc <= {partial, lo_in[XL-1:1]};         // Add then shift right
        end
    end

    assign o_result = (lhs_neg ^ rhs_neg) ? -acc : acc;   // Restore sign

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------
    a_ready_needs_valid : assert property (@(posedge g_clk) disable iff (!g_resetn)
        $rose(o_ready) |-> $past(i_valid));

    a_cnt_in_range : assert property (@(posedge g_clk) disable iff (!g_resetn)
        step_cnt <= CW'(`FRV_MUL_STEPS));

endmodule

/* verilog/frv_pipeline_execute.sv */
// Execute stage of the integer pipeline
// Unit decode, ALU and multiplier, branch resolve, result select,
// stall logic, forwarding and the stage-3 registers

module frv_pipeline_execute (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  frv_ex_pkg::reg_addr_t  i_s2_rd,          // Destination register
    input  frv_ex_pkg::word_t      i_s2_opr_a,
    input  frv_ex_pkg::word_t      i_s2_opr_b,
    input  frv_ex_pkg::word_t      i_s2_opr_c,
    input  frv_ex_pkg::uop_t       i_s2_uop,
    input  frv_ex_pkg::fu_t        i_s2_fu,          // One-hot unit
    input  logic                   i_s2_trap,
    input  logic [1:0]             i_s2_size,
    input  logic [31:0]            i_s2_instr,
    input  logic                   i_s2_valid,
    output logic                   o_s2_busy,
    input  logic                   i_flush,
    output frv_ex_pkg::reg_addr_t  o_fwd_s2_rd,
    output frv_ex_pkg::word_t      o_fwd_s2_wdata,
    output logic                   o_fwd_s2_load,
    output logic                   o_fwd_s2_csr,
    output frv_ex_pkg::reg_addr_t  o_s3_rd,
    output frv_ex_pkg::word_t      o_s3_opr_a,
    output frv_ex_pkg::word_t      o_s3_opr_b,
    output frv_ex_pkg::uop_t       o_s3_uop,
    output frv_ex_pkg::fu_t        o_s3_fu,
    output logic                   o_s3_trap,
    output logic [1:0]             o_s3_size,
    output logic [31:0]            o_s3_instr,
    output logic                   o_s3_valid,
    input  logic                   i_s3_busy
);

    localparam int XL = $bits(frv_ex_pkg::word_t);

    logic fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic progress;
    logic ctrl_busy;

    assign fu_alu = i_s2_fu[frv_ex_pkg::FU_ALU];
    assign fu_mul = i_s2_fu[frv_ex_pkg::FU_MUL];
    assign fu_lsu = i_s2_fu[frv_ex_pkg::FU_LSU];
    assign fu_cfu = i_s2_fu[frv_ex_pkg::FU_CFU];
    assign fu_csr = i_s2_fu[frv_ex_pkg::FU_CSR];

    // ------------------------------------------------
    // Branch decode
    // ------------------------------------------------
    logic cond_beq, cond_bne, cond_blt, cond_bge, cond_bltu, cond_bgeu;
    logic cfu_cond, cfu_jalr, cfu_taken;

    assign cond_beq  = fu_cfu && i_s2_uop == frv_ex_pkg::CFU_BEQ;
    assign cond_bne  = fu_cfu && i_s2_uop == frv_ex_pkg::CFU_BNE;
    assign cond_blt  = fu_cfu && i_s2_uop == frv_ex_pkg::CFU_BLT;
    assign cond_bge  = fu_cfu && i_s2_uop == frv_ex_pkg::CFU_BGE;
    assign cond_bltu = fu_cfu && i_s2_uop == frv_ex_pkg::CFU_BLTU;
    assign cond_bgeu = fu_cfu && i_s2_uop == frv_ex_pkg::CFU_BGEU;
    assign cfu_cond  = cond_beq || cond_bne || cond_blt || cond_bge || cond_bltu || cond_bgeu;
    assign cfu_jalr  = fu_cfu && i_s2_uop == frv_ex_pkg::CFU_JALR;

    // ------------------------------------------------
    // ALU
    // ------------------------------------------------
    frv_ex_pkg::word_t alu_result, alu_add_result;
    logic              alu_lt, alu_eq;

    frv_alu u_alu (
        .i_lhs          (i_s2_opr_a),
        .i_rhs          (i_s2_opr_b),
        .i_op_add       (fu_alu && i_s2_uop == frv_ex_pkg::ALU_ADD),
        .i_op_sub       (fu_alu && i_s2_uop == frv_ex_pkg::ALU_SUB),
        .i_op_xor       (fu_alu && i_s2_uop == frv_ex_pkg::ALU_XOR),
        .i_op_or        (fu_alu && i_s2_uop == frv_ex_pkg::ALU_OR),
        .i_op_and       (fu_alu && i_s2_uop == frv_ex_pkg::ALU_AND),
        .i_op_shf       (fu_alu && (i_s2_uop == frv_ex_pkg::ALU_SLL ||
                                    i_s2_uop == frv_ex_pkg::ALU_SRL ||
                                    i_s2_uop == frv_ex_pkg::ALU_SRA)),
        .i_op_shf_left  (fu_alu && i_s2_uop == frv_ex_pkg::ALU_SLL),
        .i_op_shf_arith (fu_alu && i_s2_uop == frv_ex_pkg::ALU_SRA),
        .i_op_cmp       (fu_alu && (i_s2_uop == frv_ex_pkg::ALU_SLT ||
                                    i_s2_uop == frv_ex_pkg::ALU_SLTU) || cfu_cond),
        .i_op_unsigned  (fu_alu && i_s2_uop == frv_ex_pkg::ALU_SLTU ||
                         cond_bltu || cond_bgeu),       // Branches reuse comparator
        .o_result       (alu_result),
        .o_add_result   (alu_add_result),
        .o_lt           (alu_lt),
        .o_eq           (alu_eq)
    );

    // lt already follows the unsigned strobe
    assign cfu_taken = cond_beq && alu_eq  || cond_bne && !alu_eq ||
                       (cond_blt || cond_bltu) && alu_lt ||
                       (cond_bge || cond_bgeu) && !alu_lt;

    // ------------------------------------------------
    // Multiplier
    // ------------------------------------------------
    logic              mul_valid;
    logic              imul_ready;
    logic [2*XL-1:0]   imul_product;
    frv_ex_pkg::word_t mul_result;

    assign mul_valid = i_s2_valid && fu_mul;                    // Multiply actually offered

    frv_imul u_imul (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .i_valid      (mul_valid),
        .i_restart    (progress || i_flush),
        .i_lhs_signed (i_s2_uop != frv_ex_pkg::MUL_MULHU),     // mul, mulh, mulhsu
        .i_rhs_signed (i_s2_uop == frv_ex_pkg::MUL_MUL ||
                       i_s2_uop == frv_ex_pkg::MUL_MULH),
        .i_rs1        (i_s2_opr_a),
        .i_rs2        (i_s2_opr_b),
        .o_ready      (imul_ready),
        .o_result     (imul_product)
    );

    assign mul_result = (i_s2_uop == frv_ex_pkg::MUL_MUL) ? imul_product[XL-1:0] :
                                                             imul_product[2*XL-1:XL];

    // ------------------------------------------------
    // Result select and stall
    // ------------------------------------------------
    frv_ex_pkg::word_t   n_s3_opr_a, cfu_target;
    frv_ex_pkg::uop_t    n_s3_uop;
    frv_ex_pkg::s3_ctrl_t n_s3_ctrl, s3_ctrl;
    logic                lsu_store;

    assign cfu_target = cfu_jalr ? {alu_add_result[XL-1:1], 1'b0} :
                                   {i_s2_opr_c[XL-1:1], 1'b0};     // Precomputed by decode

    assign n_s3_opr_a = {XL{fu_alu}} & alu_result     |
                        {XL{fu_mul}} & mul_result     |
                        {XL{fu_lsu}} & alu_add_result |   // Effective address
                        {XL{fu_cfu}} & cfu_target     |
                        {XL{fu_csr}} & i_s2_opr_a;

    assign n_s3_uop = !cfu_cond ? i_s2_uop :
                      cfu_taken ? frv_ex_pkg::CFU_TAKEN : frv_ex_pkg::CFU_NOT_TAKEN;

    assign lsu_store = fu_lsu && i_s2_uop == frv_ex_pkg::LSU_STORE;

    assign o_s2_busy = ctrl_busy || mul_valid && !imul_ready;
    assign progress  = i_s2_valid && !o_s2_busy;

    assign n_s3_ctrl = '{rd: i_s2_rd, uop: n_s3_uop, fu: i_s2_fu, trap: i_s2_trap,
                         size: i_s2_size, instr: i_s2_instr};

    // Forwarding sees the value about to enter stage 3
    assign o_fwd_s2_rd    = i_s2_rd;
    assign o_fwd_s2_wdata = n_s3_opr_a;
    assign o_fwd_s2_load  = fu_lsu && i_s2_uop == frv_ex_pkg::LSU_LOAD;
    assign o_fwd_s2_csr   = fu_csr;

    // ------------------------------------------------
    // Stage-3 registers
    // ------------------------------------------------
    frv_pipeline_register #(.payload_t(frv_ex_pkg::s3_ctrl_t)) u_ctrl_reg (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .i_valid (progress), .i_data (n_s3_ctrl), .o_busy (ctrl_busy),
        .i_flush (i_flush), .o_data (s3_ctrl), .o_valid (o_s3_valid), .i_busy (i_s3_busy)
    );

    frv_pipeline_register #(.payload_t(frv_ex_pkg::word_t)) u_opr_a_reg (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .i_valid (progress), .i_data (n_s3_opr_a), .o_busy (),
        .i_flush (i_flush), .o_data (o_s3_opr_a), .o_valid (), .i_busy (i_s3_busy)
    );

    // Store data or CSR write value
    frv_pipeline_register #(.payload_t(frv_ex_pkg::word_t)) u_opr_b_reg (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .i_valid (progress && (lsu_store || fu_csr)), .i_data (i_s2_opr_c), .o_busy (),
        .i_flush (i_flush), .o_data (o_s3_opr_b), .o_valid (), .i_busy (i_s3_busy)
    );

    assign o_s3_rd    = s3_ctrl.rd;
    assign o_s3_uop   = s3_ctrl.uop;
    assign o_s3_fu    = s3_ctrl.fu;
    assign o_s3_trap  = s3_ctrl.trap;
    assign o_s3_size  = s3_ctrl.size;
    assign o_s3_instr = s3_ctrl.instr;

endmodule

/* verilog/frv_pipeline_register.sv */
// Valid/busy pipeline register
// Payload type is a parameter, flush clears valid and data

module frv_pipeline_register #(
    parameter type payload_t = logic
) (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     i_valid,       // Upstream offers data
    input  payload_t i_data,
    output logic     o_busy,        // Upstream must hold
    input  logic     i_flush,
    output payload_t o_data,
    output logic     o_valid,
    input  logic     i_busy         // Downstream stalled
);

    logic load;

    assign o_busy = o_valid && i_busy;
    assign load   = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;        // Consumed, nothing new
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_flush) begin
            o_data <= '0;
        end else if (load) begin
            o_data <= i_data;
        end
    end

    // Stalled output must not move under the consumer
    a_hold_when_stalled : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_valid && i_busy && !i_flush) |=> $stable(o_data));

endmodule
